// File: common/cart_pkg.sv
package cart_pkg;

    // Three address bytes in a memory command
    localparam int ram_addr_bits_max = 24;

    localparam int cpu_addr_bits = 15;  // Offset from 0x8000
    localparam int ppu_addr_bits = 14;

    // One request on a RAM channel
    typedef struct packed {
        logic [ram_addr_bits_max-1:0] addr;
        logic                         we;
        logic [7:0]                   wdata;
    } mem_req_t;

    // Host command opcodes
    localparam logic [7:0] op_set_reg   = 8'h01;
    localparam logic [7:0] op_write_mem = 8'h02;
    localparam logic [7:0] op_read_mem  = 8'h03;

    // Mapper register indexes for SET_REG
    localparam logic [7:0] reg_prg_bank  = 8'd0;
    localparam logic [7:0] reg_chr_bank  = 8'd1;
    localparam logic [7:0] reg_mirroring = 8'd2;  // Bit 0 set selects vertical mirroring

    // Mapper configuration as written by the host
    typedef struct packed {
        logic [7:0] prg_bank;
        logic [7:0] chr_bank;
        logic       mirror_vertical;
    } cart_regs_t;

endpackage

// File: memory/cart_ram.sv
`timescale 1ns/1ps

module cart_ram #(
    parameter int RAM_ADDR_BITS = 17
) (
    input  logic                     clk,
    input  logic [RAM_ADDR_BITS-1:0] addr,
    input  logic                     we,
    input  logic [7:0]               wdata,
    output logic [7:0]               rdata
);

    logic [7:0] mem [2**RAM_ADDR_BITS];

    // Read returns the old byte when the same address is written
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// File: memory/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int RAM_ADDR_BITS = 17
) (
    input  logic               clk,
    input  logic               async_nreset,

    input  cart_pkg::mem_req_t cpu_req,
    input  logic               cpu_req_valid,
    output logic               cpu_gnt,
    output logic [7:0]         cpu_rdata,
    output logic               cpu_rvalid,

    input  cart_pkg::mem_req_t ppu_req,
    input  logic               ppu_req_valid,
    output logic               ppu_gnt,
    output logic [7:0]         ppu_rdata,
    output logic               ppu_rvalid,

    input  cart_pkg::mem_req_t api_req,
    input  logic               api_req_valid,
    output logic               api_gnt,
    output logic [7:0]         api_rdata,
    output logic               api_rvalid
);
    import cart_pkg::*;

    mem_req_t   sel_req;
    logic       ram_we;
    logic [7:0] ram_rdata;
    logic [2:0] rd_tag;  // One-hot {api, ppu, cpu} for the read now leaving the RAM

    // The CPU always wins, so its latency never stretches
    assign cpu_gnt = cpu_req_valid;
    assign ppu_gnt = ppu_req_valid & ~cpu_req_valid;
    assign api_gnt = api_req_valid & ~cpu_req_valid & ~ppu_req_valid;

    always_comb begin
        if (cpu_req_valid) begin
            sel_req = cpu_req;
        end else if (ppu_req_valid) begin
            sel_req = ppu_req;
        end else begin
            sel_req = api_req;
        end
    end

    assign ram_we = (cpu_gnt | ppu_gnt | api_gnt) & sel_req.we;

    cart_ram #(
        .RAM_ADDR_BITS(RAM_ADDR_BITS)
    ) u_cart_ram (
        .clk  (clk),
        .addr (sel_req.addr[RAM_ADDR_BITS-1:0]),
        .we   (ram_we),
        .wdata(sel_req.wdata),
        .rdata(ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            rd_tag <= '0;
        end else begin
            rd_tag <= {api_gnt & ~api_req.we,
                       ppu_gnt & ~ppu_req.we,
                       cpu_gnt & ~cpu_req.we};
        end
    end

    assign cpu_rvalid = rd_tag[0];
    assign ppu_rvalid = rd_tag[1];
    assign api_rvalid = rd_tag[2];

    assign cpu_rdata = rd_tag[0] ? ram_rdata : 8'h00;
    assign ppu_rdata = rd_tag[1] ? ram_rdata : 8'h00;
    assign api_rdata = rd_tag[2] ? ram_rdata : 8'h00;

endmodule

// File: api/api_decoder.sv
`timescale 1ns/1ps

module api_decoder #(
    parameter int RAM_ADDR_BITS = 17
) (
    input  logic                 clk,
    input  logic                 async_nreset,

    input  logic [7:0]           cmd_data,
    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    output logic [7:0]           resp_data,
    output logic                 resp_valid,
    input  logic                 resp_ready,

    output cart_pkg::cart_regs_t regs,

    output cart_pkg::mem_req_t   api_req,
    output logic                 api_req_valid,
    input  logic                 api_gnt,
    input  logic [7:0]           api_rdata,
    input  logic                 api_rvalid
);
    import cart_pkg::*;

    typedef enum logic [3:0] {
        st_start,
        st_opcode,
        st_index,
        st_value,
        st_addr_h,
        st_addr_m,
        st_addr_l,
        st_count,
        st_wdata,
        st_wreq,
        st_rreq,
        st_rwait,
        st_resp
    } state_t;

    state_t                       state;
    logic                         cmd_fire;
    logic                         is_read;
    logic [7:0]                   index_q;
    logic [7:0]                   wdata_q;
    logic [ram_addr_bits_max-1:0] addr_q;
    logic [RAM_ADDR_BITS-1:0]     cur_addr;
    logic [8:0]                   remaining;  // Bytes left in the transfer, up to 256

    // Header and write data bytes are taken only in the parsing states
    assign cmd_ready = state inside {st_opcode, st_index, st_value, st_addr_h, st_addr_m,
                                     st_addr_l, st_count, st_wdata};
    assign cmd_fire  = cmd_valid & cmd_ready;

    assign cur_addr = addr_q[RAM_ADDR_BITS-1:0];  // Address wraps at the RAM size
    assign api_req  = '{addr: ram_addr_bits_max'(cur_addr), we: ~is_read, wdata: wdata_q};

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            state         <= st_start;
            regs          <= '0;
            api_req_valid <= 1'b0;
            resp_valid    <= 1'b0;
        end else begin
            case (state)
                st_start: state <= st_opcode;
                st_opcode: begin
                    if (cmd_fire) begin
                        is_read <= (cmd_data == op_read_mem);
                        case (cmd_data)
                            op_set_reg:                state <= st_index;
                            op_write_mem, op_read_mem: state <= st_addr_h;
                            default:                   state <= st_opcode;
                        endcase
                    end
                end
                st_index: begin
                    if (cmd_fire) begin
                        index_q <= cmd_data;
                        state   <= st_value;
                    end
                end
                st_value: begin
                    if (cmd_fire) begin
                        case (index_q)
                            reg_prg_bank:  regs.prg_bank <= cmd_data;
                            reg_chr_bank:  regs.chr_bank <= cmd_data;
                            reg_mirroring: regs.mirror_vertical <= cmd_data[0];
                            default: ;  // Unknown index leaves the mapping alone
                        endcase
                        state <= st_opcode;
                    end
                end
                st_addr_h, st_addr_m, st_addr_l: begin
                    if (cmd_fire) begin
                        addr_q <= {addr_q[15:0], cmd_data};
                        state  <= (state == st_addr_h) ? st_addr_m :
                                  (state == st_addr_m) ? st_addr_l : st_count;
                    end
                end
                st_count: begin
                    if (cmd_fire) begin
                        remaining <= (cmd_data == 8'h00) ? 9'd256 : {1'b0, cmd_data};
                        if (is_read) begin
                            api_req_valid <= 1'b1;
                            state         <= st_rreq;
                        end else begin
                            state <= st_wdata;
                        end
                    end
                end
                st_wdata: begin
                    if (cmd_fire) begin
                        wdata_q       <= cmd_data;
                        api_req_valid <= 1'b1;
                        state         <= st_wreq;
                    end
                end
                st_wreq: begin
                    if (api_gnt) begin
                        api_req_valid          <= 1'b0;
                        addr_q[RAM_ADDR_BITS-1:0] <= cur_addr + 1'b1;
                        remaining              <= remaining - 1'b1;
                        state <= (remaining == 9'd1) ? st_opcode : st_wdata;
                    end
                end
                st_rreq: begin
                    if (api_gnt) begin
                        api_req_valid <= 1'b0;
                        state         <= st_rwait;
                    end
                end
                st_rwait: begin
                    if (api_rvalid) begin
                        resp_data  <= api_rdata;
                        resp_valid <= 1'b1;
                        state      <= st_resp;
                    end
                end
                st_resp: begin
                    // Next request goes out only once the host has taken this byte
                    if (resp_ready) begin
                        resp_valid                <= 1'b0;
                        addr_q[RAM_ADDR_BITS-1:0] <= cur_addr + 1'b1;
                        remaining                 <= remaining - 1'b1;
                        if (remaining == 9'd1) begin
                            state <= st_opcode;
                        end else begin
                            api_req_valid <= 1'b1;
                            state         <= st_rreq;
                        end
                    end
                end
                default: state <= st_opcode;
            endcase
        end
    end

endmodule

// File: design/bank_mapper.sv
`timescale 1ns/1ps

module bank_mapper #(
    parameter int RAM_ADDR_BITS = 17
) (
    input  logic                                clk,
    input  logic                                async_nreset,
    input  cart_pkg::cart_regs_t                regs,

    input  logic                                cpu_rd,
    input  logic [cart_pkg::cpu_addr_bits-1:0]  cpu_addr,
    input  logic                                ppu_rd,
    input  logic [cart_pkg::ppu_addr_bits-1:0]  ppu_addr,

    output logic [7:0]                          cpu_data,
    output logic                                cpu_data_valid,
    output logic [7:0]                          ppu_data,
    output logic                                ppu_data_valid,
    output logic                                ciram_a10,
    output logic                                ciram_ce,

    output cart_pkg::mem_req_t                  cpu_req,
    output logic                                cpu_req_valid,
    input  logic                                cpu_gnt,
    input  logic [7:0]                          cpu_rdata,
    input  logic                                cpu_rvalid,

    output cart_pkg::mem_req_t                  ppu_req,
    output logic                                ppu_req_valid,
    input  logic                                ppu_gnt,
    input  logic [7:0]                          ppu_rdata,
    input  logic                                ppu_rvalid
);
    import cart_pkg::*;

    // PRG fills the lower half of the RAM in 16 KB banks, CHR the upper half in 8 KB banks
    localparam int prg_bank_bits = RAM_ADDR_BITS - 15;
    localparam int chr_bank_bits = RAM_ADDR_BITS - 14;

    logic [prg_bank_bits-1:0] prg_sel;
    logic [RAM_ADDR_BITS-1:0] cpu_ram_addr;
    logic [RAM_ADDR_BITS-1:0] ppu_ram_addr;
    logic                     ppu_chr_rd;

    assign prg_sel      = cpu_addr[14] ? '1 : regs.prg_bank[prg_bank_bits-1:0];
    assign cpu_ram_addr = {1'b0, prg_sel, cpu_addr[13:0]};
    assign ppu_ram_addr = {1'b1, regs.chr_bank[chr_bank_bits-1:0], ppu_addr[12:0]};
    assign ppu_chr_rd   = ppu_rd & ~ppu_addr[13];  // Nametable reads never reach the RAM

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            cpu_req_valid <= 1'b0;
            ppu_req_valid <= 1'b0;
        end else begin
            if (cpu_rd) begin
                cpu_req_valid <= 1'b1;
            end else if (cpu_gnt) begin
                cpu_req_valid <= 1'b0;
            end
            if (ppu_chr_rd) begin
                ppu_req_valid <= 1'b1;
            end else if (ppu_gnt) begin
                ppu_req_valid <= 1'b0;
            end
        end
    end

    // Requests stay put until granted
    always_ff @(posedge clk) begin
        if (cpu_rd) begin
            cpu_req <= '{addr: ram_addr_bits_max'(cpu_ram_addr), we: 1'b0, wdata: 8'h00};
        end
        if (ppu_chr_rd) begin
            ppu_req <= '{addr: ram_addr_bits_max'(ppu_ram_addr), we: 1'b0, wdata: 8'h00};
        end
    end

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            ciram_ce  <= 1'b1;
            ciram_a10 <= 1'b0;
        end else if (ppu_rd) begin
            ciram_ce  <= ~ppu_addr[13];
            ciram_a10 <= regs.mirror_vertical ? ppu_addr[10] : ppu_addr[11];
        end
    end

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            cpu_data_valid <= 1'b0;
            ppu_data_valid <= 1'b0;
        end else begin
            cpu_data_valid <= cpu_rvalid;
            ppu_data_valid <= ppu_rvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_rvalid) begin
            cpu_data <= cpu_rdata;
        end
        if (ppu_rvalid) begin
            ppu_data <= ppu_rdata;
        end
    end

endmodule

// File: design/cart_top.sv
`timescale 1ns/1ps

module cart_top #(
    parameter int RAM_ADDR_BITS = 17
) (
    input  logic                               clk,
    input  logic                               async_nreset,

    input  logic [7:0]                         cmd_data,
    input  logic                               cmd_valid,
    output logic                               cmd_ready,
    output logic [7:0]                         resp_data,
    output logic                               resp_valid,
    input  logic                               resp_ready,

    input  logic                               cpu_rd,
    input  logic [cart_pkg::cpu_addr_bits-1:0] cpu_addr,
    output logic [7:0]                         cpu_data,
    output logic                               cpu_data_valid,

    input  logic                               ppu_rd,
    input  logic [cart_pkg::ppu_addr_bits-1:0] ppu_addr,
    output logic [7:0]                         ppu_data,
    output logic                               ppu_data_valid,

    output logic                               ciram_a10,
    output logic                               ciram_ce
);
    import cart_pkg::*;

    cart_regs_t regs;

    // One set of signals per RAM channel
    mem_req_t   cpu_req;
    logic       cpu_req_valid;
    logic       cpu_gnt;
    logic [7:0] cpu_rdata;
    logic       cpu_rvalid;

    mem_req_t   ppu_req;
    logic       ppu_req_valid;
    logic       ppu_gnt;
    logic [7:0] ppu_rdata;
    logic       ppu_rvalid;

    mem_req_t   api_req;
    logic       api_req_valid;
    logic       api_gnt;
    logic [7:0] api_rdata;
    logic       api_rvalid;

    api_decoder #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_api_decoder (.*);

    bank_mapper #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_bank_mapper (.*);

    mem_arbiter #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_mem_arbiter (.*);

endmodule

// File: tests/cart_asserts.sv
`timescale 1ns/1ps

module cart_asserts (
    input logic clk,
    input logic async_nreset,
    input logic cpu_req_valid,
    input logic cpu_gnt,
    input logic ppu_req_valid,
    input logic ppu_gnt,
    input logic api_req_valid,
    input logic api_gnt,
    input logic cpu_rd,
    input logic cpu_data_valid,
    input logic ppu_data_valid,
    input logic resp_valid
);

    // A request that loses arbitration stays up for the next cycle
    ppu_held: assert property (@(posedge clk) disable iff (!async_nreset)
        ppu_req_valid && !ppu_gnt |=> ppu_req_valid)
        else $error("PPU request dropped before it was granted");

    api_held: assert property (@(posedge clk) disable iff (!async_nreset)
        api_req_valid && !api_gnt |=> api_req_valid)
        else $error("Host request dropped before it was granted");

    grant_retires_request: assert property (@(posedge clk) disable iff (!async_nreset)
        (!$past(cpu_gnt) || !cpu_req_valid) && (!$past(ppu_gnt) || !ppu_req_valid)
        && (!$past(api_gnt) || !api_req_valid))
        else $error("Request still pending on the cycle after its grant");

    // Mapper register, grant with RAM read, response register
    cpu_latency: assert property (@(posedge clk) disable iff (!async_nreset)
        cpu_rd |-> ##3 cpu_data_valid)
        else $error("cpu_data_valid missed its fixed slot after cpu_rd");

    reset_state: assert property (@(posedge clk)
        !async_nreset |=> !cpu_data_valid && !ppu_data_valid && !resp_valid
                          && !cpu_gnt && !ppu_gnt && !api_gnt)
        else $error("Valid or grant outputs high after reset");

endmodule

bind cart_top cart_asserts u_cart_asserts (
    .clk           (clk),
    .async_nreset  (async_nreset),
    .cpu_req_valid (cpu_req_valid),
    .cpu_gnt       (cpu_gnt),
    .ppu_req_valid (ppu_req_valid),
    .ppu_gnt       (ppu_gnt),
    .api_req_valid (api_req_valid),
    .api_gnt       (api_gnt),
    .cpu_rd        (cpu_rd),
    .cpu_data_valid(cpu_data_valid),
    .ppu_data_valid(ppu_data_valid),
    .resp_valid    (resp_valid)
);

// File: tests/cart_tb.sv
`timescale 1ns/1ps

module cart_tb;
    import cart_pkg::*;

    localparam int ram_bits = 17;
    localparam int ram_size = 1 << ram_bits;
    localparam int prg_banks = ram_size / 2 / 'h4000;
    localparam int chr_banks = ram_size / 2 / 'h2000;
    // Full RAM fill in 256 byte commands plus the smaller commands, then the bus reads
    localparam int cmd_bytes = (ram_size / 256) * 261 + 4000;
    localparam int bus_reads = 1000;
    localparam int timeout_cycles = (cmd_bytes + bus_reads) * 20 + 2000;

    logic                     clk;
    logic                     async_nreset;
    logic [7:0]               cmd_data, resp_data, cpu_data, ppu_data;
    logic                     cmd_valid, cmd_ready, resp_valid, resp_ready;
    logic                     cpu_rd, cpu_data_valid, ppu_rd, ppu_data_valid;
    logic [cpu_addr_bits-1:0] cpu_addr;
    logic [ppu_addr_bits-1:0] ppu_addr;
    logic                     ciram_a10, ciram_ce;

    logic [7:0] ref_mem [ram_size];
    logic [7:0] shadow_prg, shadow_chr, want;
    logic       shadow_mirror;
    logic [7:0] cpu_exp[$];
    logic [7:0] ppu_exp[$];
    integer     seed = 54;
    int         value_errors, other_errors, cycles;

    cart_top #(.RAM_ADDR_BITS(ram_bits)) u_cart_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_cycles) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycles);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Expected RAM location of a bus address under the shadow registers
    function automatic int ref_ram_addr(input int a, input logic is_ppu);
        int bank;
        if (is_ppu) begin
            return ram_size / 2 + (shadow_chr % chr_banks) * 'h2000 + (a % 'h2000);
        end
        bank = (a >= 'h4000) ? prg_banks - 1 : shadow_prg % prg_banks;  // Upper window is fixed
        return bank * 'h4000 + (a % 'h4000);
    endfunction

    function automatic logic ref_a10(input int a);
        return shadow_mirror ? a[10] : a[11];
    endfunction

    always @(negedge clk) begin
        if (cpu_data_valid) begin
            if (cpu_exp.size() == 0) begin
                other_errors++;
                $display("cpu_data_valid pulsed with no CPU read outstanding");
            end else begin
                want = cpu_exp.pop_front();
                if (cpu_data !== want) begin
                    value_errors++;
                    $display("Error: cpu_data = %h, expected %h", cpu_data, want);
                end
            end
        end
        if (ppu_data_valid) begin
            if (ppu_exp.size() == 0) begin
                other_errors++;
                $display("ppu_data_valid pulsed with no CHR read outstanding");
            end else begin
                want = ppu_exp.pop_front();
                if (ppu_data !== want) begin
                    value_errors++;
                    $display("Error: ppu_data = %h, expected %h", ppu_data, want);
                end
            end
        end
    end

    task automatic send_byte(input logic [7:0] b);
        cmd_data  = b;
        cmd_valid = 1'b1;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic send_header(input logic [7:0] op, input int addr, input int cnt);
        send_byte(op);
        send_byte(addr[23:16]);
        send_byte(addr[15:8]);
        send_byte(addr[7:0]);
        send_byte(cnt[7:0]);  // 0 stands for 256
    endtask

    task automatic set_reg(input logic [7:0] idx, input logic [7:0] val);
        send_byte(op_set_reg);
        send_byte(idx);
        send_byte(val);
        if (idx == reg_prg_bank) shadow_prg = val;
        if (idx == reg_chr_bank) shadow_chr = val;
        if (idx == reg_mirroring) shadow_mirror = val[0];
    endtask

    task automatic write_mem(input int addr, input int cnt);
        logic [7:0] b;
        send_header(op_write_mem, addr, cnt);
        for (int n = 0; n < ((cnt == 0) ? 256 : cnt); n++) begin
            b = 8'($random(seed));
            ref_mem[(addr + n) & (ram_size - 1)] = b;
            send_byte(b);
        end
    endtask

    task automatic read_mem(input int addr, input int cnt);
        int         n;
        logic [7:0] exp_byte;
        send_header(op_read_mem, addr, cnt);
        n = 0;
        while (n < ((cnt == 0) ? 256 : cnt)) begin
            resp_ready = ($random(seed) & 3) != 0;  // Host stalls about one cycle in four
            @(negedge clk);
            if (resp_valid && resp_ready) begin
                exp_byte = ref_mem[(addr + n) & (ram_size - 1)];
                if (resp_data !== exp_byte) begin
                    value_errors++;
                    $display("Error: resp_data = %h, expected %h", resp_data, exp_byte);
                end
                n++;
            end
            @(posedge clk);
            #1;
        end
        resp_ready = 1'b0;
    endtask

    task automatic cpu_read(input int a);
        int lat;
        cpu_addr = a[14:0];
        cpu_rd   = 1'b1;
        cpu_exp.push_back(ref_mem[ref_ram_addr(a, 1'b0)]);
        @(posedge clk);
        #1 cpu_rd = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!cpu_data_valid);
        if (lat != 3) begin
            other_errors++;
            $display("CPU read at %h took %0d cycles instead of the fixed latency", a, lat);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic ppu_read(input int a);
        ppu_addr = a[13:0];
        ppu_rd   = 1'b1;
        if (a < 'h2000) ppu_exp.push_back(ref_mem[ref_ram_addr(a, 1'b1)]);
        @(posedge clk);
        #1 ppu_rd = 1'b0;
        @(negedge clk);
        if (ciram_ce !== (a < 'h2000)) begin
            value_errors++;
            $display("Error: ciram_ce = %h, expected %h", ciram_ce, a < 'h2000);
        end
        if (a >= 'h2000 && ciram_a10 !== ref_a10(a)) begin
            value_errors++;
            $display("Error: ciram_a10 = %h, expected %h", ciram_a10, ref_a10(a));
        end
        if (a < 'h2000) begin
            while (!ppu_data_valid) @(negedge clk);
        end else begin
            repeat (4) @(negedge clk);  // Room for a stray ppu_data_valid to show up
        end
        @(posedge clk);
        #1;
    endtask

    task automatic check_mapping(input int n);
        repeat (n) cpu_read($random(seed) & 'h3FFF);
        repeat (n / 2) cpu_read('h4000 | ($random(seed) & 'h3FFF));
        repeat (n) ppu_read($random(seed) & 'h1FFF);
    endtask

    initial begin
        {async_nreset, cmd_valid, resp_ready, cpu_rd, ppu_rd} = '0;
        {cmd_data, cpu_addr, ppu_addr} = '0;
        {shadow_prg, shadow_chr, shadow_mirror} = '0;
        repeat (3) @(posedge clk);
        #1 async_nreset = 1'b1;

        for (int blk = 0; blk < ram_size / 256; blk++) write_mem(blk * 256, 0);
        write_mem('hFE0000 | (ram_size - 40), 100);  // Wraps past the end of the RAM
        read_mem(ram_size - 40, 100);
        read_mem('h00300, 0);
        read_mem(ram_size / 2 + 'h1234, 77);

        for (int v = 0; v < 6; v++) begin
            set_reg(reg_prg_bank, 8'(v * 3));
            set_reg(reg_chr_bank, 8'(v * 5 + 1));
            check_mapping(8);
        end
        for (int m = 0; m < 2; m++) begin
            set_reg(reg_mirroring, 8'(m));
            repeat (8) ppu_read('h2000 | ($random(seed) & 'h1FFF));
            ppu_read($random(seed) & 'h1FFF);
        end

        fork
            read_mem('h01234, 0);
            repeat (40) cpu_read($random(seed) & 'h7FFF);
            repeat (20) ppu_read($random(seed) & 'h1FFF);
        join

        send_byte(8'h00);
        send_byte(8'hA5);
        send_byte(8'hFF);
        set_reg(8'h09, 8'h03);
        check_mapping(8);
        read_mem('h00300, 64);

        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
common/cart_pkg.sv
memory/cart_ram.sv
memory/mem_arbiter.sv
api/api_decoder.sv
design/bank_mapper.sv
design/cart_top.sv
tests/cart_asserts.sv
tests/cart_tb.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module cart_tb \
    -o cart_sim > build.log 2>&1 &&
./obj_dir/cart_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "Build or simulation ended with an error"; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
